// ==== vlog.f ====
cmd_pkg.sv
cmd_fifo.sv
cvita_hdr_parser.sv
cmd_pkt_proc.sv
shell_regs.sv
user_regs.sv
rb_combine.sv
cmd_subsys_top.sv
cmd_subsys_props.sv
tb_cmd_subsys.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cmd_subsys
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG) || { echo "No verdict in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_cmd_subsys.sv ====
// Testbench for the command subsystem that sends command packets and checks every response beat
module tb_cmd_subsys import cmd_pkg::*; ();

  localparam int       CLK_PERIOD      = 100;
  localparam bit       USE_TIME        = 1'b1;
  localparam sr_addr_t SR_RB_ADDR      = 8'd0;
  localparam sr_addr_t SR_RB_ADDR_USER = 8'd1;
  localparam sr_addr_t SR_USER_BASE    = 8'd128;
  localparam rb_addr_t RB_USER_SEL     = 8'd16;
  localparam int       NUM_RAND        = 12;
  localparam int       NUM_PKTS        = 6 + NUM_RAND;
  // A timed wait plus heavy back-pressure stays well below this many cycles per packet
  localparam int       WORST_CYCLES    = 300;
  localparam int       TIMEOUT         = NUM_PKTS * WORST_CYCLES * CLK_PERIOD;

  logic       clk;
  logic       reset;
  logic       i_clear;
  axis_beat_t i_cmd;
  logic       i_cmd_valid;
  logic       o_cmd_ready;
  vita_time_t i_vita_time;
  axis_beat_t o_resp;
  logic       o_resp_valid;
  logic       i_resp_ready;

  // Reference model of the banks and the readback selection
  sr_data_t    shell_m [8];
  sr_data_t    user_m [4];
  sr_data_t    user_cnt;
  rb_addr_t    rb_addr_m;
  rb_addr_t    rb_addr_user_m;
  logic [39:0] pay_q [$];
  axis_beat_t  exp_q [$];
  logic        time_q [$];
  logic        rand_ready;
  logic [15:0] lfsr;

  cmd_subsys_top #(
    .FIFO_SIZE(5), .USE_TIME(USE_TIME), .SR_RB_ADDR(SR_RB_ADDR),
    .SR_RB_ADDR_USER(SR_RB_ADDR_USER), .SR_SHELL_BASE(8'd0), .NUM_SHELL(8),
    .SR_USER_BASE(SR_USER_BASE), .NUM_USER(4), .RB_USER_SEL(RB_USER_SEL)
  ) dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    i_vita_time = '0;
    forever begin
      @(posedge clk);
      i_vita_time <= i_vita_time + 64'd1;
    end
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // Response ready is either always high or one fresh LFSR bit per cycle
  initial begin
    i_resp_ready = 1'b0;
    lfsr         = 16'd91;
    forever begin
      @(posedge clk);
      if (rand_ready) begin
        lfsr = lfsr_next(lfsr);
        i_resp_ready <= lfsr[0];
      end else begin
        i_resp_ready <= 1'b1;
      end
    end
  end

  function automatic int unsigned prop_fail_count();
    return dut.u_props.fail_hold + dut.u_props.fail_stb + dut.u_props.fail_rb +
           dut.u_props.fail_last + dut.u_props.fail_reset;
  endfunction

  task automatic mismatch_stop(input string msg);
    $display("CHECK FAILED at time %0t: %s", $time, msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "response mismatch");
  endtask

  task automatic abort_run(input string msg);
    $display("Error at time %0t: %s", $time, msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "unexpected response");
  endtask

  task automatic model_write(input logic [39:0] word);
    sr_addr_t addr;
    sr_data_t data;
    addr = word[39:32];
    data = word[31:0];
    if (addr < 8'd8) begin
      shell_m[addr[2:0]] = data;
    end
    // The user base is aligned, so the low bits pick the register
    if (addr >= SR_USER_BASE && addr < SR_USER_BASE + 8'd4) begin
      user_m[addr[1:0]] = data;
      user_cnt = user_cnt + 32'd1;
    end
    if (addr == SR_RB_ADDR) begin
      rb_addr_m = data[7:0];
    end else if (addr == SR_RB_ADDR_USER) begin
      rb_addr_user_m = data[7:0];
    end
  endtask

  function automatic rb_data_t expected_readback();
    if (rb_addr_m == RB_USER_SEL) begin
      return {user_cnt, (rb_addr_user_m < 8'd4) ? user_m[rb_addr_user_m[1:0]] : 32'd0};
    end else if (rb_addr_m < 8'd8) begin
      return {32'd0, shell_m[rb_addr_m[2:0]]};
    end
    return '0;
  endfunction

  task automatic send_beat(input logic last, input logic [63:0] data);
    @(posedge clk);
    i_cmd       <= {last, data};
    i_cmd_valid <= 1'b1;
    @(negedge clk);
    while (!o_cmd_ready) begin
      @(negedge clk);
    end
  endtask

  // Sends one packet with the words in pay_q and queues the response it should get
  task automatic issue_cmd(input pkt_type_e ptype, input logic [11:0] seq,
                           input logic timed, input vita_time_t cmd_time);
    cvita_hdr_t hdr;
    cvita_hdr_t rsp;
    int         n;
    n            = pay_q.size();
    hdr.pkt_type = ptype;
    hdr.has_time = timed;
    hdr.eob      = 1'b0;
    hdr.seqnum   = seq;
    hdr.pkt_len  = 16'((1 + int'(timed) + n) * 8);
    hdr.sid      = {4'h0, seq, 16'hc0de};
    if (ptype == pkt_cmd && n > 0) begin
      foreach (pay_q[i]) begin
        model_write(pay_q[i]);
      end
      rsp          = hdr;
      rsp.pkt_type = pkt_resp;
      rsp.has_time = USE_TIME;
      rsp.pkt_len  = USE_TIME ? 16'd24 : 16'd16;
      rsp.sid      = {hdr.sid[15:0], hdr.sid[31:16]};
      exp_q.push_back({1'b0, rsp});
      time_q.push_back(1'b0);
      if (USE_TIME) begin
        // Only a lower bound is known for the time word
        exp_q.push_back({1'b0, timed ? cmd_time - 64'd2 : 64'd0});
        time_q.push_back(1'b1);
      end
      exp_q.push_back({1'b1, expected_readback()});
      time_q.push_back(1'b0);
    end
    send_beat(!timed && n == 0, hdr);
    if (timed) begin
      send_beat(n == 0, cmd_time);
    end
    foreach (pay_q[i]) begin
      send_beat(i == n - 1, {24'd0, pay_q[i]});
    end
  endtask

  task automatic wait_drain();
    @(posedge clk);
    i_cmd_valid <= 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (20) @(negedge clk);
  endtask

  initial begin : check_resp
    axis_beat_t exp_beat;
    logic       is_time;
    forever begin
      @(negedge clk);
      if (o_resp_valid && i_resp_ready) begin
        if (exp_q.size() == 0) begin
          abort_run("a response beat arrived while no response was expected");
        end else begin
          exp_beat = exp_q.pop_front();
          is_time  = time_q.pop_front();
          if (is_time) begin
            assert (!o_resp.last && o_resp.data >= exp_beat.data &&
                    o_resp.data <= i_vita_time)
              else mismatch_stop($sformatf("time word %0d, expected at least %0d",
                                           o_resp.data, exp_beat.data));
          end else begin
            assert (o_resp == exp_beat)
              else mismatch_stop($sformatf("response beat %h, expected %h", o_resp, exp_beat));
          end
        end
      end
    end
  end

  // Protocol checker failures end the run at once
  initial begin : prop_watch
    forever begin
      @(negedge clk);
      if (prop_fail_count() != 0) begin
        $display("Protocol assertion failed at time %0t", $time);
        $display("Simulation finished: FAIL");
        $fatal(1, "protocol assertions failed");
      end
    end
  end

  initial begin
    #(TIMEOUT);
    $display("Timeout: the expected responses did not all arrive");
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin : main
    int unsigned prop_fails;
    reset          = 1'b1;
    i_clear        = 1'b0;
    i_cmd          = '0;
    i_cmd_valid    = 1'b0;
    rand_ready     = 1'b0;
    user_cnt       = '0;
    rb_addr_m      = '0;
    rb_addr_user_m = '0;
    for (int i = 0; i < 8; i++) begin
      shell_m[i] = '0;
    end
    for (int i = 0; i < 4; i++) begin
      user_m[i] = '0;
    end
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    // Long untimed command that writes shell register 2 and reads it back
    pay_q.delete();
    pay_q.push_back({8'd2, 32'h1234_5678});
    pay_q.push_back({SR_RB_ADDR, 32'd2});
    issue_cmd(pkt_cmd, 12'h011, 1'b0, '0);
    wait_drain();

    // User bank readback with the write count on top
    pay_q.delete();
    pay_q.push_back({8'd128, 32'haaaa_0001});
    pay_q.push_back({8'd129, 32'hbbbb_0002});
    pay_q.push_back({SR_RB_ADDR_USER, 32'd1});
    pay_q.push_back({SR_RB_ADDR, 32'(RB_USER_SEL)});
    issue_cmd(pkt_cmd, 12'h022, 1'b0, '0);
    wait_drain();

    pay_q.delete();
    pay_q.push_back({8'd3, 32'hcafe_0003});
    pay_q.push_back({SR_RB_ADDR, 32'd3});
    issue_cmd(pkt_cmd, 12'h033, 1'b1, i_vita_time + 64'd60);
    wait_drain();

    // Data packet and empty timed command are dropped, the next command still answers
    pay_q.delete();
    pay_q.push_back({8'd4, 32'hdead_0004});
    issue_cmd(pkt_data, 12'h044, 1'b0, '0);
    pay_q.delete();
    issue_cmd(pkt_cmd, 12'h045, 1'b1, i_vita_time + 64'd10);
    pay_q.push_back({8'd5, 32'hbeef_0005});
    pay_q.push_back({SR_RB_ADDR, 32'd5});
    issue_cmd(pkt_cmd, 12'h046, 1'b0, '0);
    wait_drain();

    rand_ready = 1'b1;
    for (int k = 0; k < NUM_RAND; k++) begin
      pay_q.delete();
      pay_q.push_back({8'(2 + k % 6), 32'h5000_0000 + 32'(k)});
      pay_q.push_back({8'(128 + k % 4), 32'h7000_0000 + 32'(k)});
      if (k % 2 == 1) begin
        pay_q.push_back({SR_RB_ADDR_USER, 32'(k % 4)});
        pay_q.push_back({SR_RB_ADDR, 32'(RB_USER_SEL)});
      end else begin
        pay_q.push_back({SR_RB_ADDR, 32'(2 + k % 6)});
      end
      issue_cmd(pkt_cmd, 12'(12'h100 + k), k % 4 == 3, i_vita_time + 64'd20);
    end
    wait_drain();

    prop_fails = prop_fail_count();
    if (prop_fails == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("Protocol assertions failed %0d times", prop_fails);
      $display("Simulation finished: FAIL");
      $fatal(1, "protocol assertions failed");
    end
  end

endmodule

// ==== cmd_subsys_props.sv ====
// Protocol checker for the response stream, the settings strobe and the readback strobe
module cmd_subsys_props import cmd_pkg::*; #(
  parameter bit USE_TIME = 1'b1
) (
  input logic       clk,
  input logic       reset,
  input set_bus_t   i_set,
  input logic       i_rb_stb,
  input logic       i_pay_valid,
  input logic       i_pay_ready,
  input axis_beat_t i_resp,
  input logic       i_resp_valid,
  input logic       i_resp_ready,
  input logic       i_cmd_ready
);

  int unsigned fail_hold  = 0;
  int unsigned fail_stb   = 0;
  int unsigned fail_rb    = 0;
  int unsigned fail_last  = 0;
  int unsigned fail_reset = 0;
  logic [1:0]  beat_cnt;

  // Accepted beats of the response packet in flight
  always_ff @(posedge clk) begin
    if (reset) begin
      beat_cnt <= '0;
    end else if (i_resp_valid && i_resp_ready) begin
      beat_cnt <= i_resp.last ? 2'd0 : beat_cnt + 2'd1;
    end
  end

  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    i_resp_valid && !i_resp_ready |=> i_resp_valid && $stable(i_resp))
    else begin
      fail_hold = fail_hold + 1;
      $error("response beat changed or dropped while stalled");
    end

  // Every cycle with the strobe up stands for one accepted payload word
  a_set_stb: assert property (@(posedge clk) disable iff (reset)
    i_set.stb |-> $past(i_pay_valid && i_pay_ready))
    else begin
      fail_stb = fail_stb + 1;
      $error("settings strobe without an accepted payload word");
    end

  a_rb_stb: assert property (@(posedge clk) disable iff (reset)
    i_rb_stb == $past(i_set.stb, 2))
    else begin
      fail_rb = fail_rb + 1;
      $error("readback strobe does not trail the settings strobe by two cycles");
    end

  a_resp_last: assert property (@(posedge clk) disable iff (reset)
    USE_TIME && i_resp_valid && i_resp.last |-> beat_cnt == 2'd2)
    else begin
      fail_last = fail_last + 1;
      $error("response last beat is not the third beat");
    end

  a_reset_low: assert property (@(posedge clk)
    reset |=> !i_set.stb && !i_rb_stb && !i_resp_valid && !i_cmd_ready)
    else begin
      fail_reset = fail_reset + 1;
      $error("control output high right after reset");
    end

endmodule

// Attach the checker to every instance of the subsystem top
bind cmd_subsys_top cmd_subsys_props #(.USE_TIME(USE_TIME)) u_props (
  .clk(clk), .reset(reset), .i_set(set_bus), .i_rb_stb(rb_stb),
  .i_pay_valid(pay_valid), .i_pay_ready(pay_ready),
  .i_resp(o_resp), .i_resp_valid(o_resp_valid), .i_resp_ready(i_resp_ready),
  .i_cmd_ready(o_cmd_ready)
);

// ==== cmd_subsys_top.sv ====
// Command subsystem top with the input FIFO, header parser, processor, register banks and combiner
module cmd_subsys_top import cmd_pkg::*; #(
  parameter int       FIFO_SIZE       = 5,
  parameter bit       USE_TIME        = 1'b1,
  parameter sr_addr_t SR_RB_ADDR      = 8'd0,
  parameter sr_addr_t SR_RB_ADDR_USER = 8'd1,
  parameter sr_addr_t SR_SHELL_BASE   = 8'd0,
  parameter int       NUM_SHELL       = 8,
  parameter sr_addr_t SR_USER_BASE    = 8'd128,
  parameter int       NUM_USER        = 4,
  parameter rb_addr_t RB_USER_SEL     = 8'd16
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       i_clear,
  input  axis_beat_t i_cmd,
  input  logic       i_cmd_valid,
  output logic       o_cmd_ready,
  input  vita_time_t i_vita_time,
  output axis_beat_t o_resp,
  output logic       o_resp_valid,
  input  logic       i_resp_ready
);

  axis_beat_t fifo_data;
  logic       fifo_valid;
  logic       fifo_ready;
  cvita_hdr_t hdr;
  vita_time_t pkt_time;
  axis_beat_t pay_data;
  logic       pay_valid;
  logic       pay_ready;
  set_bus_t   set_bus;
  rb_addr_t   rb_addr;
  rb_addr_t   rb_addr_user;
  rb_data_t   shell_rb_data;
  rb_data_t   user_rb_data;
  rb_data_t   rb_data;
  logic       rb_stb;

  cmd_fifo #(.FIFO_SIZE(FIFO_SIZE)) u_fifo (
    .clk(clk), .reset(reset), .i_clear(i_clear),
    .i_data(i_cmd), .i_valid(i_cmd_valid), .o_ready(o_cmd_ready),
    .o_data(fifo_data), .o_valid(fifo_valid), .i_ready(fifo_ready)
  );

  cvita_hdr_parser u_parser (
    .clk(clk), .reset(reset), .i_clear(i_clear),
    .i_data(fifo_data), .i_valid(fifo_valid), .o_ready(fifo_ready),
    .o_hdr(hdr), .o_time(pkt_time),
    .o_data(pay_data), .o_valid(pay_valid), .i_ready(pay_ready)
  );

  cmd_pkt_proc #(
    .USE_TIME(USE_TIME), .SR_RB_ADDR(SR_RB_ADDR), .SR_RB_ADDR_USER(SR_RB_ADDR_USER)
  ) u_proc (
    .clk(clk), .reset(reset),
    .i_hdr(hdr), .i_time(pkt_time),
    .i_data(pay_data), .i_valid(pay_valid), .o_ready(pay_ready),
    .i_vita_time(i_vita_time), .o_set(set_bus),
    .o_rb_addr(rb_addr), .o_rb_addr_user(rb_addr_user),
    .i_rb_stb(rb_stb), .i_rb_data(rb_data),
    .o_resp(o_resp), .o_resp_valid(o_resp_valid), .i_resp_ready(i_resp_ready)
  );

  shell_regs #(.SR_SHELL_BASE(SR_SHELL_BASE), .NUM_SHELL(NUM_SHELL)) u_shell (
    .clk(clk), .reset(reset), .i_set(set_bus),
    .i_rb_addr(rb_addr), .o_rb_data(shell_rb_data)
  );

  user_regs #(.SR_USER_BASE(SR_USER_BASE), .NUM_USER(NUM_USER)) u_user (
    .clk(clk), .reset(reset), .i_set(set_bus),
    .i_rb_addr_user(rb_addr_user), .o_rb_data(user_rb_data)
  );

  rb_combine #(.RB_USER_SEL(RB_USER_SEL)) u_rb (
    .clk(clk), .reset(reset), .i_set(set_bus), .i_rb_addr(rb_addr),
    .i_shell_data(shell_rb_data), .i_user_data(user_rb_data),
    .o_rb_stb(rb_stb), .o_rb_data(rb_data)
  );

endmodule

// ==== rb_combine.sv ====
// Readback combiner that picks the shell or user bank result and makes the readback strobe
module rb_combine import cmd_pkg::*; #(
  parameter rb_addr_t RB_USER_SEL = 8'd16
) (
  input  logic     clk,
  input  logic     reset,
  input  set_bus_t i_set,
  input  rb_addr_t i_rb_addr,
  input  rb_data_t i_shell_data,
  input  rb_data_t i_user_data,
  output logic     o_rb_stb,
  output rb_data_t o_rb_data
);

  logic stb_d1;

  // The strobe trails the write by the bank update plus one sampling register
  always_ff @(posedge clk) begin
    if (reset) begin
      stb_d1   <= 1'b0;
      o_rb_stb <= 1'b0;
    end else begin
      stb_d1   <= i_set.stb;
      o_rb_stb <= stb_d1;
    end
  end

  // Sample once the banks show the result of the write
  always_ff @(posedge clk) begin
    if (stb_d1) begin
      o_rb_data <= (i_rb_addr == RB_USER_SEL) ? i_user_data : i_shell_data;
    end
  end

endmodule

// ==== user_regs.sv ====
// User register bank with a running count of writes into the bank
module user_regs import cmd_pkg::*; #(
  parameter sr_addr_t SR_USER_BASE = 8'd128,
  parameter int       NUM_USER     = 4
) (
  input  logic     clk,
  input  logic     reset,
  input  set_bus_t i_set,
  input  rb_addr_t i_rb_addr_user,
  output rb_data_t o_rb_data
);

  sr_data_t regs [NUM_USER];
  sr_data_t wr_count;
  logic     hit;

  always_comb begin
    hit = 1'b0;
    for (int i = 0; i < NUM_USER; i++) begin
      if (i_set.addr == sr_addr_t'(SR_USER_BASE + i)) begin
        hit = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_count <= '0;
      for (int i = 0; i < NUM_USER; i++) begin
        regs[i] <= '0;
      end
    end else if (i_set.stb && hit) begin
      wr_count <= wr_count + 1'b1;
      for (int i = 0; i < NUM_USER; i++) begin
        if (i_set.addr == sr_addr_t'(SR_USER_BASE + i)) begin
          regs[i] <= i_set.data;
        end
      end
    end
  end

  // Count goes in the upper word, selected register in the lower word
  always_comb begin
    o_rb_data = {wr_count, 32'd0};
    for (int i = 0; i < NUM_USER; i++) begin
      if (i_rb_addr_user == rb_addr_t'(i)) begin
        o_rb_data[31:0] = regs[i];
      end
    end
  end

endmodule

// ==== shell_regs.sv ====
// Shell register bank written from the settings bus, where the readback address writes also land
module shell_regs import cmd_pkg::*; #(
  parameter sr_addr_t SR_SHELL_BASE = 8'd0,
  parameter int       NUM_SHELL     = 8
) (
  input  logic     clk,
  input  logic     reset,
  input  set_bus_t i_set,
  input  rb_addr_t i_rb_addr,
  output rb_data_t o_rb_data
);

  sr_data_t regs [NUM_SHELL];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_SHELL; i++) begin
        regs[i] <= '0;
      end
    end else if (i_set.stb) begin
      for (int i = 0; i < NUM_SHELL; i++) begin
        if (i_set.addr == sr_addr_t'(SR_SHELL_BASE + i)) begin
          regs[i] <= i_set.data;
        end
      end
    end
  end

  // Readback index counts from zero, anything past the bank reads as zero
  always_comb begin
    o_rb_data = '0;
    for (int i = 0; i < NUM_SHELL; i++) begin
      if (i_rb_addr == rb_addr_t'(i)) begin
        o_rb_data = rb_data_t'(regs[i]);
      end
    end
  end

endmodule

// ==== cmd_pkt_proc.sv ====
// Command packet processor that turns payload words into settings writes and answers with readback
module cmd_pkt_proc import cmd_pkg::*; #(
  parameter bit       USE_TIME        = 1'b1,
  parameter sr_addr_t SR_RB_ADDR      = 8'd0,
  parameter sr_addr_t SR_RB_ADDR_USER = 8'd1
) (
  input  logic       clk,
  input  logic       reset,
  input  cvita_hdr_t i_hdr,
  input  vita_time_t i_time,
  input  axis_beat_t i_data,
  input  logic       i_valid,
  output logic       o_ready,
  input  vita_time_t i_vita_time,
  output set_bus_t   o_set,
  output rb_addr_t   o_rb_addr,
  output rb_addr_t   o_rb_addr_user,
  input  logic       i_rb_stb,
  input  rb_data_t   i_rb_data,
  output axis_beat_t o_resp,
  output logic       o_resp_valid,
  input  logic       i_resp_ready
);

  typedef enum logic [3:0] {
    st_head,
    st_time,
    st_timed_wait,
    st_data,
    st_set_wait,
    st_readback,
    st_resp_head,
    st_resp_time,
    st_resp_data,
    st_drop
  } state_e;

  state_e     state;
  cvita_hdr_t hdr_q;
  cvita_hdr_t resp_hdr;
  vita_time_t resp_time;
  vita_time_t cmd_time_m2;
  rb_data_t   rb_hold;
  sr_addr_t   cmd_addr;
  logic       beat_in;
  logic       resp_out;

  assign beat_in  = i_valid & o_ready;
  assign resp_out = o_resp_valid & i_resp_ready;
  assign cmd_addr = i_data.data[39:32];

  // Response header keeps the seqnum and swaps source and destination IDs
  always_comb begin
    resp_hdr          = hdr_q;
    resp_hdr.pkt_type = pkt_resp;
    resp_hdr.has_time = USE_TIME;
    resp_hdr.eob      = 1'b0;
    resp_hdr.pkt_len  = USE_TIME ? 16'd24 : 16'd16;
    resp_hdr.sid      = {hdr_q.sid[15:0], hdr_q.sid[31:16]};
  end

  // Release two cycles early to cover the register stages up to the banks
  always_ff @(posedge clk) begin
    cmd_time_m2 <= i_time - 64'd2;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= st_head;
      o_ready        <= 1'b0;
      o_set.stb      <= 1'b0;
      o_resp_valid   <= 1'b0;
      o_rb_addr      <= '0;
      o_rb_addr_user <= '0;
    end else begin
      case (state)
        // The parser has already taken the header, so look at it once payload shows up
        st_head: begin
          if (i_valid) begin
            hdr_q <= i_hdr;
            if (i_hdr.pkt_type != pkt_cmd) begin
              o_ready <= 1'b1;
              state   <= st_drop;
            end else if (i_hdr.has_time) begin
              state <= st_time;
            end else begin
              o_set.vtime <= '0;
              o_ready     <= 1'b1;
              state       <= st_data;
            end
          end
        end

        st_time: begin
          o_set.vtime <= i_time;
          if (USE_TIME) begin
            state <= st_timed_wait;
          end else begin
            o_ready <= 1'b1;
            state   <= st_data;
          end
        end

        st_timed_wait: begin
          if (i_vita_time >= cmd_time_m2) begin
            o_ready <= 1'b1;
            state   <= st_data;
          end
        end

        // One settings write per payload word
        st_data: begin
          if (beat_in) begin
            o_set.stb  <= 1'b1;
            o_set.addr <= cmd_addr;
            o_set.data <= i_data.data[31:0];
            if (cmd_addr == SR_RB_ADDR) begin
              o_rb_addr <= i_data.data[7:0];
            end else if (cmd_addr == SR_RB_ADDR_USER) begin
              o_rb_addr_user <= i_data.data[7:0];
            end
            if (i_data.last) begin
              o_ready <= 1'b0;
              state   <= st_set_wait;
            end
          end else begin
            o_set.stb <= 1'b0;
          end
        end

        // Stay until the strobe has been low a cycle, so readback strobes from
        // earlier words of a long packet go by before we listen
        st_set_wait: begin
          o_set.stb <= 1'b0;
          if (!o_set.stb) begin
            state <= st_readback;
          end
        end

        st_readback: begin
          if (i_rb_stb) begin
            resp_time    <= i_vita_time;
            rb_hold      <= i_rb_data;
            o_resp.last  <= 1'b0;
            o_resp.data  <= resp_hdr;
            o_resp_valid <= 1'b1;
            state        <= st_resp_head;
          end
        end

        st_resp_head: begin
          if (resp_out) begin
            if (USE_TIME) begin
              o_resp.last <= 1'b0;
              o_resp.data <= resp_time;
              state       <= st_resp_time;
            end else begin
              o_resp.last <= 1'b1;
              o_resp.data <= rb_hold;
              state       <= st_resp_data;
            end
          end
        end

        st_resp_time: begin
          if (resp_out) begin
            o_resp.last <= 1'b1;
            o_resp.data <= rb_hold;
            state       <= st_resp_data;
          end
        end

        st_resp_data: begin
          if (resp_out) begin
            o_resp_valid <= 1'b0;
            state        <= st_head;
          end
        end

        // Swallow the rest of a packet that is not a command
        st_drop: begin
          if (beat_in && i_data.last) begin
            o_ready <= 1'b0;
            state   <= st_head;
          end
        end

        default: state <= st_head;
      endcase
    end
  end

endmodule

// ==== cvita_hdr_parser.sv ====
// CVITA header parser that latches the header and time word and forwards only payload beats
module cvita_hdr_parser import cmd_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       i_clear,
  input  axis_beat_t i_data,
  input  logic       i_valid,
  output logic       o_ready,
  output cvita_hdr_t o_hdr,
  output vita_time_t o_time,
  output axis_beat_t o_data,
  output logic       o_valid,
  input  logic       i_ready
);

  typedef enum logic [1:0] {
    ph_head,
    ph_time,
    ph_payload
  } phase_e;

  phase_e     phase;
  cvita_hdr_t in_hdr;
  logic       beat_in;

  assign in_hdr = cvita_hdr_t'(i_data.data);

  // Header and time beats are always taken here, payload waits for the consumer
  assign o_ready = (phase == ph_payload) ? i_ready : 1'b1;
  assign o_valid = (phase == ph_payload) & i_valid;
  assign o_data  = i_data;
  assign beat_in = i_valid & o_ready;

  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      phase <= ph_head;
    end else if (beat_in) begin
      case (phase)
        ph_head: begin
          // A header-only packet leaves us waiting for the next header
          if (!i_data.last) begin
            phase <= in_hdr.has_time ? ph_time : ph_payload;
          end
        end
        ph_time: begin
          phase <= i_data.last ? ph_head : ph_payload;
        end
        ph_payload: begin
          if (i_data.last) begin
            phase <= ph_head;
          end
        end
        default: phase <= ph_head;
      endcase
    end
  end

  // Fields hold until the next header or time beat arrives
  always_ff @(posedge clk) begin
    if (beat_in && phase == ph_head) begin
      o_hdr <= in_hdr;
    end
    if (beat_in && phase == ph_time) begin
      o_time <= i_data.data;
    end
  end

endmodule

// ==== cmd_fifo.sv ====
// Command FIFO that buffers stream beats and their last flag in a circular buffer
module cmd_fifo import cmd_pkg::*; #(
  parameter int FIFO_SIZE = 5
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       i_clear,
  input  axis_beat_t i_data,
  input  logic       i_valid,
  output logic       o_ready,
  output axis_beat_t o_data,
  output logic       o_valid,
  input  logic       i_ready
);

  localparam int DEPTH = 2 ** FIFO_SIZE;

  axis_beat_t mem [DEPTH];
  logic [FIFO_SIZE:0] wr_ptr;
  logic [FIFO_SIZE:0] rd_ptr;
  logic full;
  logic empty;
  logic push;
  logic pop;
  logic up;

  // The extra pointer bit tells a full buffer from an empty one
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[FIFO_SIZE] != rd_ptr[FIFO_SIZE]) &&
                 (wr_ptr[FIFO_SIZE-1:0] == rd_ptr[FIFO_SIZE-1:0]);

  // Input side opens one cycle after reset is released
  assign o_ready = up & ~full;
  assign o_valid = ~empty;
  assign o_data  = mem[rd_ptr[FIFO_SIZE-1:0]];

  assign push = i_valid & o_ready;
  assign pop  = o_valid & i_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      up     <= 1'b0;
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      up <= 1'b1;
      if (i_clear) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
      end else begin
        if (push) begin
          wr_ptr <= wr_ptr + 1'b1;
        end
        if (pop) begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[FIFO_SIZE-1:0]] <= i_data;
    end
  end

endmodule

// ==== cmd_pkg.sv ====
// Command subsystem package with the shared widths, stream beat, header and settings bus types
package cmd_pkg;

  typedef logic [7:0]  sr_addr_t;
  typedef logic [31:0] sr_data_t;
  typedef logic [63:0] vita_time_t;
  typedef logic [7:0]  rb_addr_t;
  typedef logic [63:0] rb_data_t;

  // CVITA packet types as they appear in the top two header bits
  typedef enum logic [1:0] {
    pkt_data = 2'b00,
    pkt_cmd  = 2'b10,
    pkt_resp = 2'b11
  } pkt_type_e;

  // One 64-bit stream beat with its end-of-packet flag
  typedef struct packed {
    logic        last;
    logic [63:0] data;
  } axis_beat_t;

  // Header word layout, most significant field first
  typedef struct packed {
    pkt_type_e   pkt_type;
    logic        has_time;
    logic        eob;
    logic [11:0] seqnum;
    logic [15:0] pkt_len;
    logic [31:0] sid;
  } cvita_hdr_t;

  // Settings bus carrying one write per cycle with stb high
  typedef struct packed {
    logic       stb;
    sr_addr_t   addr;
    sr_data_t   data;
    vita_time_t vtime;
  } set_bus_t;

endpackage
